// ==== gstmcu_bus.f ====
+incdir+sim
verilog/mcu_bus_pkg.sv
verilog/mcu_reg_pkg.sv
verilog/clk_enable_gen.sv
verilog/addr_decode.sv
verilog/reg_file.sv
verilog/bus_timing.sv
verilog/gstmcu_bus.sv
sim/tb_gstmcu_bus.sv

// ==== Makefile ====
TOP = tb_gstmcu_bus

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f gstmcu_bus.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_gstmcu_tests.svh ====
`ifndef TB_GSTMCU_TESTS_SVH
`define TB_GSTMCU_TESTS_SVH

    // Low byte registers and the bits each one implements
    localparam int NUM_LO_REGS = 12;
    localparam logic [23:0] LO_REG_ADDR [NUM_LO_REGS] = '{
        24'hFF8001, 24'hFF8201, 24'hFF8203, 24'hFF820D, 24'hFF820F, 24'hFF8901,
        24'hFF8903, 24'hFF8905, 24'hFF8907, 24'hFF890F, 24'hFF8911, 24'hFF8913
    };
    localparam logic [7:0] LO_REG_MASK [NUM_LO_REGS] = '{
        8'h0F, 8'h3F, 8'hFF, 8'hFE, 8'hFF, 8'h0F,
        8'h3F, 8'hFF, 8'hFE, 8'h3F, 8'hFF, 8'hFE
    };
    localparam logic [23:0] MODE_ADDR = 24'hFF8260;
    localparam logic [23:0] SYNC_ADDR = 24'hFF820A;
    localparam logic [23:0] CART_ADDR = 24'hFF9000;

    // Expected {rom_n, ram_n, mfpcs_n, rtccs_n, acia_cs_n, sndcs}, rom_idx -1 for none
    function automatic logic [12:0] expect_sel(input int rom_idx, input bit ram,
                                               input bit mfp, input bit rtc,
                                               input bit acia, input bit snd);
        logic [7:0] rom_v;
        rom_v = 8'hFF;
        if (rom_idx >= 0) rom_v[rom_idx] = 1'b0;
        return {rom_v, !ram, !mfp, !rtc, !acia, snd};
    endfunction

    task automatic check_select(input logic [23:0] baddr, input logic [FC_W-1:0] fcv,
                                input logic vma_low, input logic [12:0] exp);
        start_cycle(baddr, fcv, 1'b1, vma_low, 16'h0000);
        check_eq($sformatf("selects at %h", baddr),
                 {rom_n, ram_n, mfpcs_n, rtccs_n, acia_cs_n, sndcs}, exp);
        cpu_idle();
    endtask

    task automatic test_reset_state();
        logic [15:0] data;
        check_eq("dtack_n_o", dtack_n, 1'b1);
        check_eq("berr_n_o", berr_n, 1'b1);
        check_eq("vpa_n_o", vpa_n, 1'b1);
        check_eq("iack_n_o", iack_n, 1'b1);
        check_eq("rom_n_o", rom_n, 8'hFF);
        check_eq("fcs_n_o", fcs_n, 1'b1);
        check_eq("rtcrd_n_o", rtcrd_n, 1'b1);
        check_eq("rtcwr_n_o", rtcwr_n, 1'b1);
        check_eq("sndir_o", sndir, 1'b0);
        check_eq("selects", {rom_n, ram_n, mfpcs_n, rtccs_n, acia_cs_n, sndcs},
                 expect_sel(-1, 0, 0, 0, 0, 0));
        for (int i = 0; i < NUM_LO_REGS; i++) begin
            cpu_read(LO_REG_ADDR[i], data);
            check_eq($sformatf("dout_o at %h", LO_REG_ADDR[i]), data, {8'hFF, 8'h00});
        end
        cpu_read(MODE_ADDR, data);
        check_eq("dout_o mode", data, {8'hFC, READ_FILL});
        cpu_read(SYNC_ADDR, data);
        check_eq("dout_o sync", data, {8'hFC, READ_FILL});
        cpu_read(CART_ADDR, data);
        check_eq("dout_o cart", data, {8'hFC, READ_FILL});
    endtask

    task automatic test_reg_readback();
        logic [7:0]  d;
        logic [15:0] data;
        for (int i = 0; i < NUM_LO_REGS; i++) begin
            d = 8'($urandom);
            cpu_write(LO_REG_ADDR[i], {8'($urandom), d});
            cpu_read(LO_REG_ADDR[i], data);
            check_eq($sformatf("dout_o at %h", LO_REG_ADDR[i]), data,
                     {8'hFF, d & LO_REG_MASK[i]});
        end
    endtask

    task automatic test_decode();
        logic [7:0]  d;
        logic [15:0] data;
        check_select(24'hE00000, FC_SPROG, 1'b0, expect_sel(2, 0, 0, 0, 0, 0));
        check_select(24'hE40000, FC_SPROG, 1'b0, expect_sel(1, 0, 0, 0, 0, 0));
        check_select(24'hE80000, FC_SPROG, 1'b0, expect_sel(0, 0, 0, 0, 0, 0));
        check_select(24'hD00000, FC_SPROG, 1'b0, expect_sel(6, 0, 0, 0, 0, 0));
        check_select(24'hD40000, FC_SPROG, 1'b0, expect_sel(5, 0, 0, 0, 0, 0));
        check_select(24'hFB0000, FC_SPROG, 1'b0, expect_sel(3, 0, 0, 0, 0, 0));
        check_select(24'hFA0000, FC_SPROG, 1'b0, expect_sel(4, 0, 0, 0, 0, 0));
        check_select(24'hFE0000, FC_SPROG, 1'b0, expect_sel(7, 0, 0, 0, 0, 0));
        check_select(24'hDC0000, FC_SPROG, 1'b0, expect_sel(-1, 0, 0, 0, 0, 0));
        check_select(24'h010000, FC_SDATA, 1'b0, expect_sel(-1, 1, 0, 0, 0, 0));
        check_select(24'h3F0000, FC_SDATA, 1'b0, expect_sel(-1, 1, 0, 0, 0, 0));
        check_select(24'hFFFA00, FC_SDATA, 1'b0, expect_sel(-1, 0, 1, 0, 0, 0));
        check_select(24'hFFFA40, FC_SDATA, 1'b0, expect_sel(-1, 0, 0, 0, 0, 0));
        check_select(24'hFFFC20, FC_SDATA, 1'b0, expect_sel(-1, 0, 0, 1, 0, 0));
        check_select(24'hFFFC00, FC_SDATA, 1'b1, expect_sel(-1, 0, 0, 0, 1, 0));
        check_select(24'hFF8800, FC_SDATA, 1'b0, expect_sel(-1, 0, 0, 0, 0, 1));

        start_cycle(24'hFFFFFC, FC_IACK, 1'b1, 1'b0, 16'h0000);
        check_eq("iack_n_o", iack_n, 1'b0);
        cpu_idle();
        start_cycle(24'hFFFC00, FC_SDATA, 1'b1, 1'b0, 16'h0000);
        check_eq("vpa_n_o", vpa_n, 1'b0);
        cpu_idle();

        // Mode and sync live in the upper byte
        d = 8'($urandom);
        cpu_write(MODE_ADDR, {d, 8'h00});
        check_eq("mode_o", mode, d[1:0]);
        cpu_read(MODE_ADDR, data);
        check_eq("dout_o mode", data, {6'h3F, d[1:0], READ_FILL});
        d = 8'($urandom);
        cpu_write(SYNC_ADDR, {d, 8'h00});
        check_eq("pal_o", pal, d[1]);
        cpu_read(SYNC_ADDR, data);
        check_eq("dout_o sync", data, {6'h3F, d[1], 1'b0, READ_FILL});

        // Cartridge bit moves ROM3 and ROM4 down to D8..DF
        cpu_write(CART_ADDR, 16'h0100);
        cpu_read(CART_ADDR, data);
        check_eq("dout_o cart", data, {6'h3F, 2'b01, READ_FILL});
        check_select(24'hDC0000, FC_SPROG, 1'b0, expect_sel(3, 0, 0, 0, 0, 0));
        check_select(24'hD80000, FC_SPROG, 1'b0, expect_sel(4, 0, 0, 0, 0, 0));
        check_select(24'hFB0000, FC_SPROG, 1'b0, expect_sel(-1, 0, 0, 0, 0, 0));
        check_select(24'hFA0000, FC_SPROG, 1'b0, expect_sel(-1, 0, 0, 0, 0, 0));
        cpu_write(CART_ADDR, 16'h0000);
        check_select(24'hFB0000, FC_SPROG, 1'b0, expect_sel(3, 0, 0, 0, 0, 0));
    endtask

    task automatic test_bus_error();
        int n;
        bit ack_seen;
        n = 0;
        ack_seen = 0;
        start_cycle(24'hFF8E00, FC_SDATA, 1'b1, 1'b0, 16'h0000);   // Nothing decoded here
        check_eq("dout_o[7:0]", dout[7:0], READ_FILL);
        while (berr_n && n < 300) begin
            @(posedge clk32);
            n++;
            @(negedge clk32);
            if (!dtack_n) ack_seen = 1;
        end
        check_true(!ack_seen, "DTACK asserted on an unmapped address");
        check_true(!berr_n && n >= 250 && n <= 260,
                   $sformatf("BERR after %0d cycles, expected 250 to 260", n));
        cpu_idle();
        @(posedge clk32);
        @(negedge clk32);
        check_eq("berr_n_o", berr_n, 1'b1);
    endtask

    task automatic test_ack_timing();
        int n;
        bit seen;
        bit rd;
        start_cycle(24'hE00000, FC_SPROG, 1'b1, 1'b0, 16'h0000);
        check_eq("dtack_n_o rom", dtack_n, 1'b0);
        cpu_idle();
        for (int k = 0; k < 4; k++) begin
            rd = k[0];
            repeat ($urandom_range(3, 0)) cpu_idle();   // Vary the 8 MHz phase
            start_cycle(24'hFF8800, FC_SDATA, rd, 1'b0, 16'h00A5);
            check_eq("sndcs_o", sndcs, 1'b1);
            check_eq("sndir_o", sndir, !rd);
            check_eq("dtack_n_o", dtack_n, 1'b1);
            n = 0;
            seen = 0;
            while (!seen && n < 16) begin
                @(posedge clk32);
                n++;
                @(negedge clk32);
                seen = !dtack_n;
            end
            check_true(seen && n >= 5 && n <= 8,
                       $sformatf("sound chip DTACK after %0d cycles, expected 5 to 8", n));
            cpu_idle();
            @(posedge clk32);
            @(negedge clk32);
            check_eq("dtack_n_o", dtack_n, 1'b1);
        end
    endtask

    // 8 MHz output is two cycles high, two low
    task automatic test_clk_div();
        logic [7:0] pattern;
        logic       prev;
        int         n;
        n = 0;
        @(negedge clk32);
        prev = mhz8;
        @(negedge clk32);
        while (!(mhz8 && !prev) && n < 8) begin   // Find a rising edge
            prev = mhz8;
            @(negedge clk32);
            n++;
        end
        for (int i = 7; i >= 0; i--) begin
            pattern[i] = mhz8;
            @(negedge clk32);
        end
        check_eq("mhz8_o", pattern, 8'b1100_1100);
    endtask

`endif

// ==== sim/tb_gstmcu_bus.sv ====
`timescale 1ns/1ps

module tb_gstmcu_bus import mcu_bus_pkg::*, mcu_reg_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY  = 2;
    localparam int MAX_CYCLES = 2000;  // Tests need about 900 cycles at most

    localparam logic [FC_W-1:0] FC_SDATA = 3'b101;
    localparam logic [FC_W-1:0] FC_SPROG = 3'b110;
    localparam logic [FC_W-1:0] FC_IACK  = 3'b111;

    logic                 clk32;
    logic                 isndcsb;
    logic                 as_n, rw, uds_n, lds_n, vma_n;
    logic [FC_W-1:0]      fc;
    logic [ADDR_W:1]      addr;
    logic [DATA_W-1:0]    din;
    logic [DATA_W-1:0]    dout;
    logic                 mhz8, dtack_n, berr_n, vpa_n, iack_n;
    logic [ROM_SEL_W-1:0] rom_n;
    logic                 ram_n, mfpcs_n, acia_cs_n, fcs_n, rtccs_n, rtcrd_n, rtcwr_n;
    logic                 sndcs, sndir, pal;
    logic [MODE_W-1:0]    mode;
    int                   mismatch_cnt;
    int                   fail_cnt;
    int                   cycle_cnt;

    gstmcu_bus dut (
        .clk32(clk32), .isndcsb(isndcsb), .as_n_i(as_n), .rw_i(rw), .uds_n_i(uds_n),
        .lds_n_i(lds_n), .vma_n_i(vma_n), .fc_i(fc), .addr_i(addr), .din_i(din),
        .dout_o(dout), .mhz8_o(mhz8), .dtack_n_o(dtack_n), .berr_n_o(berr_n),
        .vpa_n_o(vpa_n), .iack_n_o(iack_n), .rom_n_o(rom_n), .ram_n_o(ram_n),
        .mfpcs_n_o(mfpcs_n), .acia_cs_n_o(acia_cs_n), .fcs_n_o(fcs_n),
        .rtccs_n_o(rtccs_n), .rtcrd_n_o(rtcrd_n), .rtcwr_n_o(rtcwr_n),
        .sndcs_o(sndcs), .sndir_o(sndir), .mode_o(mode), .pal_o(pal)
    );

    initial begin
        clk32 = 1'b0;
        forever #(CLK_PERIOD / 2) clk32 = ~clk32;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk32);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, tests did not finish", cycle_cnt);
        $display("Test failed");
        $finish;
    end

    task automatic check_eq(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t ns: %s got %h, expected %h", $time, name, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("ERROR at %0t ns: %s", $time, what);
            fail_cnt++;
        end
    endtask

    task automatic drive_idle();
        as_n  = 1'b1;
        rw    = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        vma_n = 1'b1;
        fc    = FC_SDATA;
        addr  = '0;
        din   = '0;
    endtask

    // Bus cycle with both strobes, returns at the falling edge where outputs are settled
    task automatic start_cycle(input logic [23:0] baddr, input logic [FC_W-1:0] fcv,
                               input logic rd, input logic vma_low,
                               input logic [15:0] data);
        @(posedge clk32);
        #DRIVE_DLY;
        addr  = baddr[23:1];
        fc    = fcv;
        rw    = rd;
        din   = data;
        vma_n = !vma_low;
        as_n  = 1'b0;
        uds_n = 1'b0;
        lds_n = 1'b0;
        @(negedge clk32);
    endtask

    task automatic cpu_idle();
        @(posedge clk32);
        #DRIVE_DLY;
        drive_idle();
    endtask

    task automatic cpu_write(input logic [23:0] baddr, input logic [15:0] data);
        start_cycle(baddr, FC_SDATA, 1'b0, 1'b0, data);
        check_eq("dtack_n_o", dtack_n, 1'b0);   // Registers ack at once
        cpu_idle();
    endtask

    task automatic cpu_read(input logic [23:0] baddr, output logic [15:0] data);
        start_cycle(baddr, FC_SDATA, 1'b1, 1'b0, 16'h0000);
        data = dout;
        check_eq("dtack_n_o", dtack_n, 1'b0);
        cpu_idle();
    endtask

`include "tb_gstmcu_tests.svh"

    initial begin
        void'($urandom(32'h6f07));
        mismatch_cnt = 0;
        fail_cnt     = 0;
        isndcsb      = 1'b1;
        drive_idle();
        repeat (10) @(posedge clk32);
        #DRIVE_DLY;
        isndcsb = 1'b0;

        test_reset_state();
        test_reg_readback();
        test_decode();
        test_bus_error();
        test_ack_timing();
        test_clk_div();

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== verilog/gstmcu_bus.sv ====
`timescale 1ns/1ps

module gstmcu_bus import mcu_bus_pkg::*, mcu_reg_pkg::*; (
    input  logic                 clk32,
    input  logic                 isndcsb,
    input  logic                 as_n_i,
    input  logic                 rw_i,
    input  logic                 uds_n_i,
    input  logic                 lds_n_i,
    input  logic                 vma_n_i,
    input  logic [FC_W-1:0]      fc_i,
    input  logic [ADDR_W:1]      addr_i,
    input  logic [DATA_W-1:0]    din_i,
    output logic [DATA_W-1:0]    dout_o,
    output logic                 mhz8_o,
    output logic                 dtack_n_o,
    output logic                 berr_n_o,
    output logic                 vpa_n_o,
    output logic                 iack_n_o,
    output logic [ROM_SEL_W-1:0] rom_n_o,
    output logic                 ram_n_o,
    output logic                 mfpcs_n_o,
    output logic                 acia_cs_n_o,
    output logic                 fcs_n_o,
    output logic                 rtccs_n_o,
    output logic                 rtcrd_n_o,
    output logic                 rtcwr_n_o,
    output logic                 sndcs_o,
    output logic                 sndir_o,
    output logic [MODE_W-1:0]    mode_o,
    output logic                 pal_o
);

    logic     mhz8_en, reg_rd, reg_wr, uds, lds, gamecart;
    logic     snd_sel, rom_any, reg_ack, fixed_ack, as_active;
    reg_sel_e reg_sel;

    clk_enable_gen u_clk_en (
        .clk32(clk32), .isndcsb(isndcsb), .mhz8_o(mhz8_o), .mhz8_en_o(mhz8_en)
    );

    addr_decode u_decode (
        .as_n_i(as_n_i), .rw_i(rw_i), .uds_n_i(uds_n_i), .lds_n_i(lds_n_i),
        .vma_n_i(vma_n_i), .fc_i(fc_i), .addr_i(addr_i), .gamecart_i(gamecart),
        .rom_n_o(rom_n_o), .ram_n_o(ram_n_o), .mfpcs_n_o(mfpcs_n_o),
        .acia_cs_n_o(acia_cs_n_o), .fcs_n_o(fcs_n_o), .rtccs_n_o(rtccs_n_o),
        .rtcrd_n_o(rtcrd_n_o), .rtcwr_n_o(rtcwr_n_o), .sndcs_o(sndcs_o),
        .sndir_o(sndir_o), .iack_n_o(iack_n_o), .vpa_n_o(vpa_n_o),
        .reg_sel_o(reg_sel), .reg_rd_o(reg_rd), .reg_wr_o(reg_wr),
        .uds_o(uds), .lds_o(lds), .snd_sel_o(snd_sel), .rom_any_o(rom_any),
        .reg_ack_o(reg_ack), .fixed_ack_o(fixed_ack), .as_active_o(as_active)
    );

    reg_file u_regs (
        .clk32(clk32), .isndcsb(isndcsb), .reg_sel_i(reg_sel), .reg_rd_i(reg_rd),
        .reg_wr_i(reg_wr), .uds_i(uds), .lds_i(lds), .din_i(din_i),
        .dout_o(dout_o), .gamecart_o(gamecart), .mode_o(mode_o), .pal_o(pal_o)
    );

    bus_timing u_timing (
        .clk32(clk32), .isndcsb(isndcsb), .mhz8_en_i(mhz8_en),
        .as_active_i(as_active), .snd_sel_i(snd_sel), .rom_any_i(rom_any),
        .reg_ack_i(reg_ack), .fixed_ack_i(fixed_ack),
        .dtack_n_o(dtack_n_o), .berr_n_o(berr_n_o)
    );

endmodule

// ==== verilog/bus_timing.sv ====
`timescale 1ns/1ps

module bus_timing import mcu_reg_pkg::*; (
    input  logic clk32,
    input  logic isndcsb,
    input  logic mhz8_en_i,
    input  logic as_active_i,
    input  logic snd_sel_i,
    input  logic rom_any_i,
    input  logic reg_ack_i,
    input  logic fixed_ack_i,
    output logic dtack_n_o,
    output logic berr_n_o
);

    logic [SND_ACK_ENABLES-1:0]    snd_dly;
    logic [$clog2(BERR_ENABLES):0] berr_cnt;   // MSB is the timeout flag

    // Sound chip needs two 8 MHz periods before acknowledge
    always_ff @(posedge clk32 or posedge isndcsb) begin
        if (isndcsb) begin
            snd_dly <= '0;
        end else if (!snd_sel_i) begin
            snd_dly <= '0;
        end else if (mhz8_en_i) begin
            snd_dly <= {snd_dly[SND_ACK_ENABLES-2:0], 1'b1};
        end
    end

    assign dtack_n_o = ~(snd_dly[SND_ACK_ENABLES-1] | rom_any_i | reg_ack_i | fixed_ack_i);

    always_ff @(posedge clk32 or posedge isndcsb) begin
        if (isndcsb) begin
            berr_cnt <= '0;
        end else if (!as_active_i) begin
            berr_cnt <= '0;                     // Idle strobe restarts the timeout
        end else if (mhz8_en_i && !berr_cnt[$high(berr_cnt)]) begin
            berr_cnt <= berr_cnt + 1'b1;        // Holds once flagged
        end
    end

    assign berr_n_o = ~berr_cnt[$high(berr_cnt)];

    // Bus error released one cycle after the strobe goes away
    a_berr_release: assert property (@(posedge clk32) disable iff (isndcsb)
        !as_active_i |=> berr_n_o);

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import mcu_bus_pkg::*, mcu_reg_pkg::*; (
    input  logic              clk32,
    input  logic              isndcsb,
    input  reg_sel_e          reg_sel_i,
    input  logic              reg_rd_i,
    input  logic              reg_wr_i,
    input  logic              uds_i,
    input  logic              lds_i,
    input  logic [DATA_W-1:0] din_i,
    output logic [DATA_W-1:0] dout_o,
    output logic              gamecart_o,
    output logic [MODE_W-1:0] mode_o,
    output logic              pal_o
);

    logic [VADDR_W:1]   vbase, sfb, sft;
    logic [HOFF_W-1:0]  hoff;
    logic [CONF_W-1:0]  conf;
    logic [SCTL_W-1:0]  sctl;
    logic [MODE_W-1:0]  hi_bits;
    logic [BYTE_W-1:0]  lo_byte;

    always_ff @(posedge clk32 or posedge isndcsb) begin
        if (isndcsb) begin
            vbase <= '0;
            sfb <= '0;
            sft <= '0;
            hoff <= '0;
            conf <= '0;
            sctl <= '0;
            mode_o <= '0;
            pal_o <= 1'b0;
            gamecart_o <= 1'b0;
        end else if (reg_wr_i) begin
            if (uds_i) begin
                case (reg_sel_i)
                    SEL_MODE: mode_o     <= din_i[BYTE_W +: MODE_W];
                    SEL_SYNC: pal_o      <= din_i[BYTE_W+1];
                    SEL_CART: gamecart_o <= din_i[BYTE_W];
                    default: ;
                endcase
            end
            if (lds_i) begin
                case (reg_sel_i)
                    SEL_CONFIG:  conf             <= din_i[CONF_W-1:0];
                    SEL_VBASE_H: vbase[VADDR_W:16] <= din_i[VADDR_W-16:0];
                    SEL_VBASE_M: vbase[15:8]      <= din_i[7:0];
                    SEL_VBASE_L: vbase[7:1]       <= din_i[7:1];   // Word aligned
                    SEL_HOFF:    hoff             <= din_i[HOFF_W-1:0];
                    SEL_SCTL:    sctl             <= din_i[SCTL_W-1:0];
                    SEL_SFB_H:   sfb[VADDR_W:16]  <= din_i[VADDR_W-16:0];
                    SEL_SFB_M:   sfb[15:8]        <= din_i[7:0];
                    SEL_SFB_L:   sfb[7:1]         <= din_i[7:1];
                    SEL_SFT_H:   sft[VADDR_W:16]  <= din_i[VADDR_W-16:0];
                    SEL_SFT_M:   sft[15:8]        <= din_i[7:0];
                    SEL_SFT_L:   sft[7:1]         <= din_i[7:1];
                    default: ;
                endcase
            end
        end
    end

    // Readback, unused bits forced high or low as on the real chip
    always_comb begin
        hi_bits = '1;
        lo_byte = READ_FILL;
        if (reg_rd_i && uds_i) begin
            case (reg_sel_i)
                SEL_MODE: hi_bits = mode_o;
                SEL_SYNC: hi_bits = {pal_o, 1'b0};
                SEL_CART: hi_bits = {1'b0, gamecart_o};
                default:  hi_bits = '1;
            endcase
        end
        if (reg_rd_i && lds_i) begin
            case (reg_sel_i)
                SEL_CONFIG:  lo_byte = {{(BYTE_W-CONF_W){1'b0}}, conf};
                SEL_VBASE_H: lo_byte = {2'b00, vbase[VADDR_W:16]};
                SEL_VBASE_M: lo_byte = vbase[15:8];
                SEL_VBASE_L: lo_byte = {vbase[7:1], 1'b0};
                SEL_HOFF:    lo_byte = hoff;
                SEL_SCTL:    lo_byte = {{(BYTE_W-SCTL_W){1'b0}}, sctl};
                SEL_SFB_H:   lo_byte = {2'b00, sfb[VADDR_W:16]};
                SEL_SFB_M:   lo_byte = sfb[15:8];
                SEL_SFB_L:   lo_byte = {sfb[7:1], 1'b0};
                SEL_SFT_H:   lo_byte = {2'b00, sft[VADDR_W:16]};
                SEL_SFT_M:   lo_byte = sft[15:8];
                SEL_SFT_L:   lo_byte = {sft[7:1], 1'b0};
                default:     lo_byte = READ_FILL;
            endcase
        end
    end

    assign dout_o = {{(BYTE_W-MODE_W){1'b1}}, hi_bits, lo_byte};

    // Decoder direction must be one way per cycle
    a_rd_wr_excl: assert property (@(posedge clk32) disable iff (isndcsb)
        !(reg_rd_i && reg_wr_i));

endmodule

// ==== verilog/addr_decode.sv ====
`timescale 1ns/1ps

module addr_decode import mcu_bus_pkg::*; (
    input  logic                 as_n_i,
    input  logic                 rw_i,
    input  logic                 uds_n_i,
    input  logic                 lds_n_i,
    input  logic                 vma_n_i,
    input  logic [FC_W-1:0]      fc_i,
    input  logic [ADDR_W:1]      addr_i,
    input  logic                 gamecart_i,
    output logic [ROM_SEL_W-1:0] rom_n_o,
    output logic                 ram_n_o,
    output logic                 mfpcs_n_o,
    output logic                 acia_cs_n_o,
    output logic                 fcs_n_o,
    output logic                 rtccs_n_o,
    output logic                 rtcrd_n_o,
    output logic                 rtcwr_n_o,
    output logic                 sndcs_o,
    output logic                 sndir_o,
    output logic                 iack_n_o,
    output logic                 vpa_n_o,
    output reg_sel_e             reg_sel_o,
    output logic                 reg_rd_o,
    output logic                 reg_wr_o,
    output logic                 uds_o,
    output logic                 lds_o,
    output logic                 snd_sel_o,
    output logic                 rom_any_o,
    output logic                 reg_ack_o,
    output logic                 fixed_ack_o,
    output logic                 as_active_o
);

    logic ias, ivma, fcx, idev, dev_cyc, overlap, rom, rvec, snd_sel;
    logic [ROM_SEL_W-1:0] rom_sel;

    assign ias     = ~as_n_i;
    assign ivma    = ~vma_n_i;
    assign uds_o   = ~uds_n_i;
    assign lds_o   = ~lds_n_i;
    assign fcx     = fc_i[0] ^ fc_i[1];     // User or supervisor, data or program
    assign idev    = fc_i[2] & fcx & (addr_i[23:16] == DEV_PAGE);
    assign dev_cyc = idev & ias;

    assign iack_n_o = ~(ias & (&fc_i) & (addr_i[3:1] == 3'b110));
    assign vpa_n_o  = ~(dev_cyc & (addr_i[15:9] == VPA_WIN));

    // Peripheral chip selects
    assign mfpcs_n_o   = ~(dev_cyc & (addr_i[15:6] == MFP_WIN));
    assign acia_cs_n_o = ~(idev & ivma & (addr_i[15:3] == ACIA_WIN));   // 6800 style cycle
    assign fcs_n_o     = ~(dev_cyc & uds_o & lds_o & (addr_i[15:2] == FDC_WIN));
    assign rtccs_n_o   = ~(dev_cyc & (addr_i[15:5] == RTC_WIN));
    assign rtcrd_n_o   = ~(rw_i & ivma & lds_o);
    assign rtcwr_n_o   = ~(~rw_i & ivma & lds_o);

    assign snd_sel   = dev_cyc & (addr_i[15:8] == SND_WIN);
    assign snd_sel_o = snd_sel;
    assign sndir_o   = snd_sel & ~rw_i;
    assign sndcs_o   = snd_sel & ~addr_i[1];

    // ROM, with cartridge remap and the reset vector overlay
    assign overlap = |addr_i[15:3];
    assign rom     = ias & rw_i & fcx;
    assign rvec    = ias & rw_i & ~overlap & fc_i[2] & fcx;

    assign rom_sel[0] = rom & (addr_i[23:18] == ROM0_WIN);
    assign rom_sel[1] = rom & (addr_i[23:18] == ROM1_WIN);
    assign rom_sel[2] = (rvec & (addr_i[23:16] == 8'h00)) | (rom & (addr_i[23:18] == ROM2_WIN));
    assign rom_sel[3] = rom & (gamecart_i ? (addr_i[23:18] == ROM3_CART)
                                          : (addr_i[23:16] == ROM3_PAGE));
    assign rom_sel[4] = rom & (gamecart_i ? (addr_i[23:18] == ROM4_CART)
                                          : (addr_i[23:16] == ROM4_PAGE));
    assign rom_sel[5] = rom & (addr_i[23:18] == ROM5_WIN);
    assign rom_sel[6] = rom & (addr_i[23:18] == ROM6_WIN);
    assign rom_sel[7] = rom & (addr_i[23:13] == ROMP_WIN);
    assign rom_n_o    = ~rom_sel;
    assign rom_any_o  = |rom_sel;

    // Low 64k is RAM except the vector overlay and system page in user mode
    assign ram_n_o = ~(ias & (((|addr_i[21:16]) & fcx & ~addr_i[23] & ~addr_i[22])
                   | ((addr_i[23:16] == 8'h00)
                      & (overlap | fcx | fc_i[2] | (addr_i[15:11] == 5'd0)))));

    always_comb begin
        reg_sel_o = SEL_NONE;
        if (dev_cyc) begin
            if (addr_i[15:4] == CONF_WIN && addr_i[3:1] == 3'd0) reg_sel_o = SEL_CONFIG;
            else if (addr_i[15:1] == MODE_WIN) reg_sel_o = SEL_MODE;
            else if (addr_i[15:1] == CART_WIN) reg_sel_o = SEL_CART;
            else if (addr_i[15:1] == SYNC_WIN) reg_sel_o = SEL_SYNC;
            else if (addr_i[15:4] == VREG_WIN) begin
                case (addr_i[3:1])
                    3'd0:    reg_sel_o = SEL_VBASE_H;
                    3'd1:    reg_sel_o = SEL_VBASE_M;
                    3'd6:    reg_sel_o = SEL_VBASE_L;
                    3'd7:    reg_sel_o = SEL_HOFF;
                    default: reg_sel_o = SEL_NONE;   // Video counter, not kept
                endcase
            end else if (addr_i[15:5] == SREG_WIN) begin
                case (addr_i[4:1])
                    4'd0:    reg_sel_o = SEL_SCTL;
                    4'd1:    reg_sel_o = SEL_SFB_H;
                    4'd2:    reg_sel_o = SEL_SFB_M;
                    4'd3:    reg_sel_o = SEL_SFB_L;
                    4'd7:    reg_sel_o = SEL_SFT_H;
                    4'd8:    reg_sel_o = SEL_SFT_M;
                    4'd9:    reg_sel_o = SEL_SFT_L;
                    default: reg_sel_o = SEL_NONE;
                endcase
            end
        end
    end

    assign reg_rd_o    = dev_cyc & rw_i;
    assign reg_wr_o    = dev_cyc & ~rw_i;
    assign reg_ack_o   = dev_cyc & ((addr_i[15:4] == CONF_WIN) | (addr_i[15:4] == VREG_WIN)
                       | (addr_i[15:5] == SREG_WIN) | (addr_i[15:1] == MODE_WIN));
    assign fixed_ack_o = dev_cyc & ((addr_i[15:1] == JOY_WIN) | (addr_i[15:1] == CART_WIN)
                       | (addr_i[15:1] == SYNC_WIN));
    assign as_active_o = ias;

endmodule

// ==== verilog/clk_enable_gen.sv ====
`timescale 1ns/1ps

module clk_enable_gen import mcu_reg_pkg::*; (
    input  logic clk32,
    input  logic isndcsb,
    output logic mhz8_o,
    output logic mhz8_en_o
);

    logic [$clog2(CLK_DIV)-1:0] phase;

    always_ff @(posedge clk32 or posedge isndcsb) begin
        if (isndcsb) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;      // Free running, wraps each 8 MHz period
        end
    end

    assign mhz8_o    = phase[$high(phase)];
    assign mhz8_en_o = &phase;          // Last phase of the period

    // Enable must stay a single-cycle pulse
    a_en_pulse: assert property (@(posedge clk32) disable iff (isndcsb)
        mhz8_en_o |=> !mhz8_en_o);

endmodule

// ==== verilog/mcu_reg_pkg.sv ====
package mcu_reg_pkg;

    // Register widths
    localparam int VADDR_W = 21;     // Video base and sound frame, bits 21..1
    localparam int HOFF_W  = 8;
    localparam int CONF_W  = 4;
    localparam int SCTL_W  = 4;      // Enable plus three control bits
    localparam int MODE_W  = 2;

    localparam logic [7:0] READ_FILL = 8'hFF;   // Unselected byte on readback

    // Bus timing, counted in 8 MHz enables
    localparam int SND_ACK_ENABLES = 2;
    localparam int BERR_ENABLES    = 64;
    localparam int CLK_DIV         = 4;         // clk32 cycles per 8 MHz period

endpackage

// ==== verilog/mcu_bus_pkg.sv ====
package mcu_bus_pkg;

    localparam int ADDR_W    = 23;              // Word address, bits 23..1
    localparam int DATA_W    = 16;
    localparam int BYTE_W    = 8;
    localparam int FC_W      = 3;
    localparam int ROM_SEL_W = 8;               // ROM0..ROM6 plus ROMP

    localparam logic [7:0]  DEV_PAGE  = 8'hFF;

    // Device windows, compared against the upper part of the device page
    localparam logic [6:0]  VPA_WIN   = {4'hF, 3'b110};     // FFFCxx-FFFDxx
    localparam logic [9:0]  MFP_WIN   = {8'hFA, 2'b00};     // FFFA0x-FFFA3x
    localparam logic [12:0] ACIA_WIN  = {12'hFC0, 1'b0};    // FFFC00-FFFC07
    localparam logic [13:0] FDC_WIN   = {12'h860, 2'b01};   // FF8604-FF8607
    localparam logic [10:0] RTC_WIN   = {8'hFC, 3'b001};    // FFFC2x-FFFC3x
    localparam logic [7:0]  SND_WIN   = 8'h88;              // FF88xx
    localparam logic [10:0] SREG_WIN  = {8'h89, 3'b000};    // FF890x-FF891x
    localparam logic [11:0] VREG_WIN  = 12'h820;            // FF8200-FF820F
    localparam logic [11:0] CONF_WIN  = 12'h800;            // FF8000-FF800F
    localparam logic [14:0] CART_WIN  = {12'h900, 3'b000};
    localparam logic [14:0] SYNC_WIN  = {12'h820, 3'b101};  // FF820A
    localparam logic [14:0] MODE_WIN  = {12'h826, 3'b000};  // FF8260
    localparam logic [14:0] JOY_WIN   = {12'h920, 3'b001};

    // ROM windows on A[23:18], except the paged ones
    localparam logic [5:0]  ROM0_WIN  = {4'hE, 2'b10};      // E8-EB
    localparam logic [5:0]  ROM1_WIN  = {4'hE, 2'b01};      // E4-E7
    localparam logic [5:0]  ROM2_WIN  = {4'hE, 2'b00};      // E0-E3
    localparam logic [5:0]  ROM3_CART = {4'hD, 2'b11};
    localparam logic [5:0]  ROM4_CART = {4'hD, 2'b10};
    localparam logic [5:0]  ROM5_WIN  = {4'hD, 2'b01};
    localparam logic [5:0]  ROM6_WIN  = {4'hD, 2'b00};
    localparam logic [7:0]  ROM3_PAGE = 8'hFB;
    localparam logic [7:0]  ROM4_PAGE = 8'hFA;
    localparam logic [10:0] ROMP_WIN  = {8'hFE, 3'b000};    // A[23:13]

    typedef enum logic [3:0] {
        SEL_NONE, SEL_CONFIG, SEL_VBASE_H, SEL_VBASE_M, SEL_VBASE_L, SEL_HOFF,
        SEL_MODE, SEL_SYNC, SEL_CART, SEL_SCTL, SEL_SFB_H, SEL_SFB_M, SEL_SFB_L,
        SEL_SFT_H, SEL_SFT_M, SEL_SFT_L
    } reg_sel_e;

endpackage
